/* dv/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 20,                   // In ns
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset drops on a rising edge like any other stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* dv/tb_host_fifo_ctl.sv */
`default_nettype none

module tb_host_fifo_ctl import host_fifo_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [7:0]  DEV_ID      = 8'h5a;
    localparam logic [7:0]  VER_MAJ     = 8'h02;
    localparam logic [7:0]  VER_MIN     = 8'h07;
    localparam logic [15:0] SEND_N      = 16'd5;   // Countdown length
    localparam logic [15:0] INACT_TICKS = 16'd6;   // Idle threshold

    // ------------------------------------------------------------------------
    // Cycle budgets, summed into the run limit
    // ------------------------------------------------------------------------
    localparam int BUDGET_RESET = 10;
    localparam int BUDGET_ROUTE = 60;
    localparam int BUDGET_LOOP  = 120;
    localparam int BUDGET_READ  = 150;
    localparam int BUDGET_WRITE = 100;
    localparam int BUDGET_SEND  = 100;
    localparam int BUDGET_STALL = 200;
    localparam int CYCLE_LIMIT  = BUDGET_RESET + BUDGET_ROUTE + BUDGET_LOOP + BUDGET_READ
                                  + BUDGET_WRITE + BUDGET_SEND + BUDGET_STALL;

    logic        clk;
    logic        rst;
    logic        i_com_valid;
    rx_word_u    i_com_word;
    logic        i_com_ready;
    tx_word_t    o_com_word;
    logic        o_com_wr_en;
    tlp_out_t    o_tlp;
    tlp_in_t     i_tlp;
    logic        o_tlp_rd_en;

    logic [31:0] lfsr_state;
    logic [15:0] ctrl_exp;                             // Expected rw bytes 2..3
    tx_word_t    tx_seen[$];                           // Words caught on the host side
    int          cycle_count = 0;

    tb_clk_gen #(.HALF_PERIOD(20), .RESET_CYCLES(5)) u_clk_gen (.clk(clk), .rst(rst));

    host_fifo_ctl #(
        .DEVICE_ID(DEV_ID), .VERSION_MAJOR(VER_MAJ), .VERSION_MINOR(VER_MIN), .FIFO_DEPTH(16)
    ) dut0 (
        .clk(clk), .rst(rst), .i_com_valid(i_com_valid), .i_com_word(i_com_word),
        .i_com_ready(i_com_ready), .o_com_word(o_com_word), .o_com_wr_en(o_com_wr_en),
        .o_tlp(o_tlp), .i_tlp(i_tlp), .o_tlp_rd_en(o_tlp_rd_en)
    );

    // Output monitor, sampled away from the rising edge
    always @(negedge clk) begin
        if (!rst && o_com_wr_en) begin
            tx_seen.push_back(o_com_word);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: tests still running after %0d cycles", cycle_count);
            $display("ERRORS FOUND");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic halt_run();
        $display("ERRORS FOUND");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compare_tx(input string name, input tx_word_t got, input tx_word_t exp);
        if (got !== exp) begin
            $display("ERR %s: got data=%h tag=%h ctx=%h, expected data=%h tag=%h ctx=%h",
                     name, got.data, got.tag, got.ctx, exp.data, exp.tag, exp.ctx);
            halt_run();
        end
    endtask

    task automatic compare_tlp(input string name, input tlp_out_t got, input tlp_out_t exp);
        if (got !== exp) begin
            $display("ERR %s: got valid=%h data=%h last=%h, expected valid=%h data=%h last=%h",
                     name, got.valid, got.data, got.last, exp.valid, exp.data, exp.last);
            halt_run();
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic rx_word_u data_word(input logic [7:0] magic, input rx_type_e rtype,
                                           input logic [1:0] ctx, input logic [31:0] payload);
        rx_word_u w;
        w               = '0;
        w.frame.magic   = magic;
        w.frame.rtype   = rtype;
        w.frame.ctx     = ctx;
        w.frame.payload = payload;
        return w;
    endfunction

    function automatic rx_word_u cmd_word(input logic rd, input logic wr, input logic [15:0] addr,
                                          input logic [15:0] mask, input logic [15:0] value);
        rx_word_u w;
        w             = '0;
        w.cmd.magic   = RX_MAGIC;
        w.cmd.rtype   = RX_CMD;
        w.cmd.rd_flag = rd;
        w.cmd.wr_flag = wr;
        w.cmd.addr    = addr;
        w.cmd.mask    = {mask[7:0], mask[15:8]};       // Wire order is byte swapped
        w.cmd.value   = {value[7:0], value[15:8]};
        return w;
    endfunction

    function automatic tx_word_t cmd_tx(input logic [31:0] data);
        tx_word_t t;
        t.data = data;
        t.tag  = TX_CMD;
        t.ctx  = 2'b00;
        return t;
    endfunction

    function automatic logic [15:0] masked(input logic [15:0] old, input logic [15:0] mask,
                                           input logic [15:0] value);
        return (old & ~mask) | (value & mask);
    endfunction

    task automatic send_word(input rx_word_u w);
        @(posedge clk);
        i_com_valid <= 1'b1;
        i_com_word  <= w;
        @(posedge clk);                                // Accepting edge
        i_com_valid <= 1'b0;
    endtask

    task automatic expect_tx(input tx_word_t exp);
        tx_word_t got;
        while (tx_seen.size() == 0) @(negedge clk);
        got = tx_seen.pop_front();
        compare_tx("o_com_word", got, exp);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (o_tlp.valid || o_com_wr_en || o_tlp_rd_en || tx_seen.size() != 0) begin
                $display("Output activity seen where the DUT should stay silent");
                halt_run();
            end
        end
    endtask

    task automatic reg_read(input logic [15:0] addr, input logic [15:0] value);
        send_word(cmd_word(1'b1, 1'b0, addr, 16'h0000, 16'h0000));
        expect_tx(cmd_tx({addr, value[7:0], value[15:8]}));    // Value comes back swapped
    endtask

    task automatic reg_write(input logic [15:0] addr, input logic [15:0] mask,
                             input logic [15:0] value);
        send_word(cmd_word(1'b0, 1'b1, addr, mask, value));
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic route_words();
        tlp_out_t    exp;
        logic [31:0] pay;
        for (int i = 0; i < 3; i++) begin
            pay = take_bits(32);
            @(posedge clk);
            i_com_valid <= 1'b1;
            i_com_word  <= data_word(RX_MAGIC, RX_TLP, {1'b0, i[0]}, pay);
            @(negedge clk);
            if (o_tlp.valid) begin
                $display("o_tlp.valid rose before the accepting edge");
                halt_run();
            end
            @(posedge clk);
            i_com_valid <= 1'b0;
            @(negedge clk);
            exp.valid = 1'b1;
            exp.data  = pay;
            exp.last  = i[0];
            compare_tlp("o_tlp", o_tlp, exp);
            @(negedge clk);
            if (o_tlp.valid) begin
                $display("o_tlp.valid stayed high longer than one cycle");
                halt_run();
            end
        end
        // Bad magic and CFG type go nowhere
        send_word(data_word(8'h76, RX_TLP, 2'b01, take_bits(32)));
        expect_quiet(4);
        send_word(data_word(8'h7f, RX_LOOP, 2'b10, take_bits(32)));
        expect_quiet(4);
        send_word(data_word(RX_MAGIC, RX_CFG, 2'b00, take_bits(32)));
        expect_quiet(8);
    endtask

    task automatic loop_words();
        tx_word_t    exp_list[8];
        logic [31:0] rnd;
        for (int i = 0; i < 8; i++) begin
            rnd                = take_bits(2);
            exp_list[i].ctx    = rnd[1:0];
            exp_list[i].data   = take_bits(32);
            exp_list[i].tag    = TX_LOOP;
            send_word(data_word(RX_MAGIC, RX_LOOP, exp_list[i].ctx, exp_list[i].data));
        end
        for (int i = 0; i < 8; i++) begin
            expect_tx(exp_list[i]);
        end
    endtask

    task automatic read_registers();
        reg_read(16'h0000, 16'hab89);
        reg_read(16'h0004, 16'd32);                    // Read-only byte count
        reg_read(16'h0008, {VER_MIN, VER_MAJ});
        reg_read(16'h000a, {8'h00, DEV_ID});
        reg_read(16'h0020, 16'h0000);                  // Past the ro bank
        reg_read(16'h8000, 16'hefcd);
        reg_read(16'h8010, 16'h0000);                  // Past the rw bank
    endtask

    task automatic write_masked();
        logic [15:0] shadow;
        shadow = 16'h0000;
        reg_write(16'h800c, 16'h0ff0, 16'hffff);
        shadow = masked(shadow, 16'h0ff0, 16'hffff);
        reg_read(16'h800c, shadow);
        reg_write(16'h800c, 16'hf00f, 16'ha5a5);
        shadow = masked(shadow, 16'hf00f, 16'ha5a5);
        reg_read(16'h800c, shadow);
        reg_write(16'h0000, 16'hffff, 16'h1234);       // ro bank ignores it
        reg_read(16'h0000, 16'hab89);
        reg_read(16'h8000, 16'hefcd);                  // rw magic untouched too
    endtask

    task automatic count_down();
        reg_write(16'h8004, 16'hffff, SEND_N);
        ctrl_exp = masked(ctrl_exp, 16'h0002, 16'h0002);
        reg_write(16'h8002, 16'h0002, 16'h0002);       // Send-count enable
        for (int k = int'(SEND_N); k > 0; k--) begin
            expect_tx(cmd_tx({16'hfffe, 16'(k)}));
        end
        reg_read(16'h8004, 16'h0000);
    endtask

    task automatic stall_and_idle();
        tlp_in_t     tlp;
        tx_word_t    exp_list[3];
        logic [31:0] rnd;
        tlp.valid = 1'b1;
        tlp.data  = take_bits(32);
        tlp.first = 1'b1;
        tlp.last  = 1'b0;
        exp_list[0].data = tlp.data;
        exp_list[0].tag  = TX_TLP;
        exp_list[0].ctx  = {tlp.first, tlp.last};
        @(posedge clk);
        i_com_ready <= 1'b0;
        i_tlp       <= tlp;
        for (int i = 1; i < 3; i++) begin
            rnd              = take_bits(2);
            exp_list[i].ctx  = rnd[1:0];
            exp_list[i].data = take_bits(32);
            exp_list[i].tag  = TX_LOOP;
            send_word(data_word(RX_MAGIC, RX_LOOP, exp_list[i].ctx, exp_list[i].data));
        end
        expect_quiet(10);                              // Everything holds
        @(posedge clk);
        i_com_ready <= 1'b1;
        @(negedge clk);
        while (!o_tlp_rd_en) @(negedge clk);
        @(posedge clk);
        i_tlp.valid <= 1'b0;                           // Returned TLP popped
        for (int i = 0; i < 3; i++) begin
            expect_tx(exp_list[i]);
        end
        // Inactivity timer, one notification only
        reg_write(16'h8008, 16'hffff, INACT_TICKS);
        ctrl_exp = masked(ctrl_exp, 16'h0001, 16'h0001);
        reg_write(16'h8002, 16'h0001, 16'h0001);
        expect_tx(cmd_tx({16'hffff, 16'hcede}));
        ctrl_exp[0] = 1'b0;                            // Enable clears itself
        expect_quiet(3 * int'(INACT_TICKS) + 10);
        reg_read(16'h8002, ctrl_exp);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        i_com_valid = 1'b0;
        i_com_word  = '0;
        i_com_ready = 1'b1;
        i_tlp       = '0;
        lfsr_state  = 32'h5158;
        ctrl_exp    = 16'h0000;
        @(negedge rst);
        expect_quiet(2);                               // Idle straight out of reset
        route_words();
        loop_words();
        read_registers();
        write_masked();
        count_down();
        stall_and_idle();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* host_fifo_ctl.f */
hw/host_fifo_pkg.sv
hw/sync_fifo.sv
hw/rx_router.sv
hw/tx_arbiter.sv
hw/ctl_regfile.sv
hw/host_fifo_ctl.sv
dv/tb_clk_gen.sv
dv/tb_host_fifo_ctl.sv

/* hw/ctl_regfile.sv */
`default_nettype none

module ctl_regfile import host_fifo_pkg::*; #(
    parameter logic [7:0] DEVICE_ID     = 8'h00,
    parameter logic [7:0] VERSION_MAJOR = 8'h00,
    parameter logic [7:0] VERSION_MINOR = 8'h00
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     i_cmd_valid,
    input  wire rx_word_u i_cmd_word,
    output logic          o_cmd_rd_en,
    input  wire logic     i_resp_almost_full,
    output logic          o_resp_wr_en,
    output fifo_word_t    o_resp_din,
    input  wire logic     i_com_wr_en,
    input  wire logic     i_com_ready
);

    localparam int RO_BITS = RO_BYTES * 8;
    localparam int RW_BITS = RW_BYTES * 8;
    localparam int RO_IW   = $clog2(RO_BITS);
    localparam int RW_IW   = $clog2(RW_BITS);

    logic [63:0]        uptime;
    logic [63:0]        inact_base;
    logic [RO_BITS-1:0] ro;
    logic [RW_BITS-1:0] rw;

    logic [15:0]        cmd_addr;
    logic [15:0]        cmd_value;
    logic [15:0]        cmd_mask;
    logic [17:0]        cmd_bit;
    logic               f_rw;
    logic               in_range;
    logic               cmd_read;
    logic               cmd_write;
    logic [15:0]        rd_data;
    logic [RW_BITS-1:0] wr_sel;
    logic [RW_BITS-1:0] wr_val;
    logic [15:0]        sc_count;
    logic               send_go;
    logic               inact_go;

    // ------------------------------------------------------------------------
    // Read-only bank
    // ------------------------------------------------------------------------
    assign ro = {inact_base,                           // +018 inactivity base
                 uptime,                               // +010 uptime ticks
                 40'h0,                                // +00b slack
                 DEVICE_ID,                            // +00a
                 VERSION_MINOR,                        // +009
                 VERSION_MAJOR,                        // +008
                 32'(RO_BYTES),                        // +004 byte count
                 16'h0,
                 RO_MAGIC};                            // +000

    // Command decode, one command popped per cycle
    assign o_cmd_rd_en = i_cmd_valid;
    assign cmd_addr    = i_cmd_word.cmd.addr;
    assign cmd_value   = {i_cmd_word.cmd.value[7:0], i_cmd_word.cmd.value[15:8]};
    assign cmd_mask    = {i_cmd_word.cmd.mask[7:0], i_cmd_word.cmd.mask[15:8]};
    assign cmd_bit     = {cmd_addr[14:0], 3'b000};
    assign f_rw        = cmd_addr[15];
    assign in_range    = f_rw ? (cmd_bit <= 18'(RW_BITS - 16)) : (cmd_bit <= 18'(RO_BITS - 16));
    assign cmd_read    = i_cmd_valid & i_cmd_word.cmd.rd_flag;
    assign cmd_write   = i_cmd_valid & i_cmd_word.cmd.wr_flag & f_rw;   // ro bank ignores writes

    always_comb begin
        rd_data = 16'h0000;                            // Past the bank end
        if (in_range) begin
            rd_data = f_rw ? rw[cmd_bit[RW_IW-1:0] +: 16] : ro[cmd_bit[RO_IW-1:0] +: 16];
        end
    end

    assign wr_sel = RW_BITS'(cmd_mask) << cmd_bit[RW_IW-1:0];
    assign wr_val = RW_BITS'(cmd_value & cmd_mask) << cmd_bit[RW_IW-1:0];

    // ------------------------------------------------------------------------
    // Actions
    // ------------------------------------------------------------------------
    assign sc_count = rw[47:32];
    assign send_go  = rw[17] & (sc_count != 16'h0) & ~cmd_read & ~cmd_write
                      & ~i_resp_almost_full;
    assign inact_go = rw[16] & ((64'(rw[95:64]) + inact_base) < uptime)
                      & ~cmd_read & ~cmd_write & ~send_go & ~i_resp_almost_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            uptime       <= '0;
            inact_base   <= '0;
            o_resp_wr_en <= 1'b0;
            rw           <= {{(RW_BITS - 16){1'b0}}, RW_MAGIC};
        end else begin
            uptime       <= uptime + 1'b1;
            if (i_com_wr_en | ~i_com_ready) begin
                inact_base <= uptime;                  // Output busy or stalled
            end
            o_resp_wr_en <= cmd_read | send_go | inact_go;
            if (cmd_write) begin
                rw <= (rw & ~wr_sel) | wr_val;         // Masked bits only
            end else if (send_go) begin
                rw[47:32] <= sc_count - 1'b1;
            end else if (inact_go) begin
                rw[16] <= 1'b0;                        // One shot
            end
        end
    end

    // Response payload
    always_ff @(posedge clk) begin
        o_resp_din.ctx <= 2'b00;
        if (cmd_read) begin
            o_resp_din.data <= {cmd_addr, rd_data[7:0], rd_data[15:8]};
        end else if (send_go) begin
            o_resp_din.data <= {RESP_SEND_COUNT_ADDR, sc_count};
        end else if (inact_go) begin
            o_resp_din.data <= {RESP_INACT_ADDR, RESP_INACT_DATA};
        end
    end

endmodule

`default_nettype wire

/* hw/host_fifo_ctl.sv */
`default_nettype none

module host_fifo_ctl import host_fifo_pkg::*; #(
    parameter logic [7:0] DEVICE_ID     = 8'h03,
    parameter logic [7:0] VERSION_MAJOR = 8'h04,
    parameter logic [7:0] VERSION_MINOR = 8'h0e,
    parameter int         FIFO_DEPTH    = 16
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     i_com_valid,
    input  wire rx_word_u i_com_word,
    input  wire logic     i_com_ready,
    output tx_word_t      o_com_word,
    output logic          o_com_wr_en,
    output tlp_out_t      o_tlp,
    input  wire tlp_in_t  i_tlp,
    output logic          o_tlp_rd_en
);

    logic       loop_wr_en, loop_rd_en, loop_valid;
    fifo_word_t loop_din, loop_dout;
    logic       cmd_rx_wr_en, cmd_rx_rd_en, cmd_rx_valid;
    rx_word_u   cmd_rx_dout;
    logic       resp_wr_en, resp_rd_en, resp_valid, resp_almost_full;
    fifo_word_t resp_din, resp_dout;

    // ------------------------------------------------------------------------
    // Receive side
    // ------------------------------------------------------------------------
    rx_router u_rx_router (
        .clk(clk), .rst(rst), .i_com_valid(i_com_valid), .i_com_word(i_com_word),
        .o_tlp(o_tlp), .o_loop_wr_en(loop_wr_en), .o_loop_din(loop_din),
        .o_cmd_wr_en(cmd_rx_wr_en)
    );

    sync_fifo #(.WIDTH($bits(fifo_word_t)), .DEPTH(FIFO_DEPTH)) u_loop_fifo (
        .clk(clk), .rst(rst), .i_wr_en(loop_wr_en), .i_din(loop_din),
        .i_rd_en(loop_rd_en), .o_dout(loop_dout), .o_valid(loop_valid), .o_almost_full()
    );

    sync_fifo #(.WIDTH($bits(rx_word_u)), .DEPTH(FIFO_DEPTH)) u_cmd_rx_fifo (
        .clk(clk), .rst(rst), .i_wr_en(cmd_rx_wr_en), .i_din(i_com_word),   // Raw word
        .i_rd_en(cmd_rx_rd_en), .o_dout(cmd_rx_dout), .o_valid(cmd_rx_valid),
        .o_almost_full()
    );

    // Register file and its responses
    ctl_regfile #(
        .DEVICE_ID(DEVICE_ID), .VERSION_MAJOR(VERSION_MAJOR), .VERSION_MINOR(VERSION_MINOR)
    ) u_ctl_regfile (
        .clk(clk), .rst(rst), .i_cmd_valid(cmd_rx_valid), .i_cmd_word(cmd_rx_dout),
        .o_cmd_rd_en(cmd_rx_rd_en), .i_resp_almost_full(resp_almost_full),
        .o_resp_wr_en(resp_wr_en), .o_resp_din(resp_din),
        .i_com_wr_en(o_com_wr_en), .i_com_ready(i_com_ready)
    );

    sync_fifo #(.WIDTH($bits(fifo_word_t)), .DEPTH(FIFO_DEPTH)) u_cmd_tx_fifo (
        .clk(clk), .rst(rst), .i_wr_en(resp_wr_en), .i_din(resp_din),
        .i_rd_en(resp_rd_en), .o_dout(resp_dout), .o_valid(resp_valid),
        .o_almost_full(resp_almost_full)
    );

    // Transmit merge toward the host
    tx_arbiter u_tx_arbiter (
        .clk(clk), .rst(rst), .i_com_ready(i_com_ready),
        .i_tlp(i_tlp), .o_tlp_rd_en(o_tlp_rd_en),
        .i_loop_valid(loop_valid), .i_loop_dout(loop_dout), .o_loop_rd_en(loop_rd_en),
        .i_cmd_valid(resp_valid), .i_cmd_dout(resp_dout), .o_cmd_rd_en(resp_rd_en),
        .o_com_word(o_com_word), .o_com_wr_en(o_com_wr_en)
    );

endmodule

`default_nettype wire

/* hw/host_fifo_pkg.sv */
`default_nettype none

package host_fifo_pkg;

    // ------------------------------------------------------------------------
    // Incoming host word
    // ------------------------------------------------------------------------
    localparam logic [7:0] RX_MAGIC = 8'h77;    // Every routable word carries this

    // Type 1 is the config path, never routed here
    typedef enum logic [1:0] {
        RX_TLP  = 2'd0,
        RX_CFG  = 2'd1,
        RX_LOOP = 2'd2,
        RX_CMD  = 2'd3
    } rx_type_e;

    // Data view of the word, last bit of a TLP sits in ctx[0]
    typedef struct packed {
        logic [31:0] payload;                   // 63:32
        logic [19:0] rsvd;                      // 31:12
        logic [1:0]  ctx;                       // 11:10
        rx_type_e    rtype;                     // 9:8
        logic [7:0]  magic;                     // 7:0
    } rx_frame_t;

    // Command view, mask and value arrive byte swapped
    typedef struct packed {
        logic [15:0] value;                     // 63:48
        logic [15:0] mask;                      // 47:32
        logic [15:0] addr;                      // Byte address, bit 15 picks rw bank
        logic [1:0]  rsvd_hi;
        logic        wr_flag;                   // 13
        logic        rd_flag;                   // 12
        logic [1:0]  rsvd_lo;
        rx_type_e    rtype;
        logic [7:0]  magic;
    } cmd_frame_t;

    typedef union packed {
        rx_frame_t  frame;
        cmd_frame_t cmd;
    } rx_word_u;

    // ------------------------------------------------------------------------
    // Outgoing stream
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        TX_TLP  = 2'd0,
        TX_LOOP = 2'd2,
        TX_CMD  = 2'd3
    } tx_tag_e;

    typedef struct packed {
        logic [31:0] data;
        tx_tag_e     tag;
        logic [1:0]  ctx;
    } tx_word_t;

    // Loopback and response FIFO entry
    typedef struct packed {
        logic [1:0]  ctx;
        logic [31:0] data;
    } fifo_word_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic        last;
    } tlp_out_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic        first;
        logic        last;
    } tlp_in_t;

    // Register map
    localparam logic [15:0] RO_MAGIC = 16'hab89;
    localparam logic [15:0] RW_MAGIC = 16'hefcd;
    localparam int          RO_BYTES = 32;
    localparam int          RW_BYTES = 16;

    // Unsolicited responses
    localparam logic [15:0] RESP_SEND_COUNT_ADDR = 16'hfffe;
    localparam logic [15:0] RESP_INACT_ADDR      = 16'hffff;
    localparam logic [15:0] RESP_INACT_DATA      = 16'hcede;

endpackage

`default_nettype wire

/* hw/rx_router.sv */
`default_nettype none

module rx_router import host_fifo_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     i_com_valid,
    input  wire rx_word_u i_com_word,
    output tlp_out_t      o_tlp,
    output logic          o_loop_wr_en,
    output fifo_word_t    o_loop_din,
    output logic          o_cmd_wr_en
);

    logic magic_ok;
    logic tlp_hit;

    // CFG and bad magic fall through unrouted
    assign magic_ok     = i_com_valid & (i_com_word.frame.magic == RX_MAGIC);
    assign tlp_hit      = magic_ok & (i_com_word.frame.rtype == RX_TLP);
    assign o_loop_wr_en = magic_ok & (i_com_word.frame.rtype == RX_LOOP);
    assign o_cmd_wr_en  = magic_ok & (i_com_word.frame.rtype == RX_CMD);

    assign o_loop_din.ctx  = i_com_word.frame.ctx;
    assign o_loop_din.data = i_com_word.frame.payload;

    // TLP out one cycle after the accepting edge
    always_ff @(posedge clk) begin
        if (tlp_hit) begin
            o_tlp.data <= i_com_word.frame.payload;
            o_tlp.last <= i_com_word.frame.ctx[0];     // Last flag rides in ctx bit 0
        end
        if (rst) begin
            o_tlp.valid <= 1'b0;
        end else begin
            o_tlp.valid <= tlp_hit;
        end
    end

endmodule

`default_nettype wire

/* hw/sync_fifo.sv */
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 34,
    parameter int DEPTH = 16
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             i_wr_en,
    input  wire logic [WIDTH-1:0] i_din,
    input  wire logic             i_rd_en,
    output logic      [WIDTH-1:0] o_dout,
    output logic                  o_valid,
    output logic                  o_almost_full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = i_wr_en & (count != CW'(DEPTH));    // Full drops the word
    assign do_rd = i_rd_en & o_valid;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // First word fall through
    assign o_dout        = mem[rd_ptr];
    assign o_valid       = (count != '0);
    assign o_almost_full = (count >= CW'(DEPTH - 1));  // One slot left

endmodule

`default_nettype wire

/* hw/tx_arbiter.sv */
`default_nettype none

module tx_arbiter import host_fifo_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       i_com_ready,
    input  wire tlp_in_t    i_tlp,
    output logic            o_tlp_rd_en,
    input  wire logic       i_loop_valid,
    input  wire fifo_word_t i_loop_dout,
    output logic            o_loop_rd_en,
    input  wire logic       i_cmd_valid,
    input  wire fifo_word_t i_cmd_dout,
    output logic            o_cmd_rd_en,
    output tx_word_t        o_com_word,
    output logic            o_com_wr_en
);

    logic     take_any;
    tx_word_t next_word;

    // ------------------------------------------------------------------------
    // Fixed priority pick: TLP, loopback, command
    // ------------------------------------------------------------------------
    assign o_tlp_rd_en  = i_com_ready & i_tlp.valid;
    assign o_loop_rd_en = i_com_ready & ~i_tlp.valid & i_loop_valid;
    assign o_cmd_rd_en  = i_com_ready & ~i_tlp.valid & ~i_loop_valid & i_cmd_valid;
    assign take_any     = o_tlp_rd_en | o_loop_rd_en | o_cmd_rd_en;

    always_comb begin
        if (i_tlp.valid) begin
            next_word.data = i_tlp.data;
            next_word.tag  = TX_TLP;
            next_word.ctx  = {i_tlp.first, i_tlp.last};
        end else if (i_loop_valid) begin
            next_word.data = i_loop_dout.data;
            next_word.tag  = TX_LOOP;
            next_word.ctx  = i_loop_dout.ctx;
        end else begin
            next_word.data = i_cmd_dout.data;
            next_word.tag  = TX_CMD;
            next_word.ctx  = i_cmd_dout.ctx;
        end
    end

    // Output word lands the cycle after the pop
    always_ff @(posedge clk) begin
        if (take_any) begin
            o_com_word <= next_word;
        end
        if (rst) begin
            o_com_wr_en <= 1'b0;
        end else begin
            o_com_wr_en <= take_any;                   // Ready low holds every source
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; exit status follows the simulation

ROOT=$(cd "$(dirname "$0")" && pwd)
cd "$ROOT" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    -f host_fifo_ctl.f \
    --top-module tb_host_fifo_ctl \
    -Mdir obj_dir -o tb_host_fifo_ctl
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/tb_host_fifo_ctl
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit $sim_status
fi

exit 0
